//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := rv_core_tb
FILELIST  := rv_core.f
BUILD_DIR := obj_dir
SIM_ARGS  := +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

//--- rtl/rv_alu.sv
module rv_alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_t         op,
    input  logic [2:0]              funct3,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    branch_taken
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign eq    = (a == b);
    assign lt_s  = ($signed(a) < $signed(b));
    assign lt_u  = (a < b);

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = xlen'(lt_s);
            alu_sltu: result = xlen'(lt_u);
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = b;
        endcase
    end

    // Branch condition by funct3
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = eq;
            3'b001:  branch_taken = !eq;
            3'b100:  branch_taken = lt_s;
            3'b101:  branch_taken = !lt_s;
            3'b110:  branch_taken = lt_u;
            3'b111:  branch_taken = !lt_u;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

//--- rtl/rv_core.sv
module rv_core (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           imem_we,
    input  logic [rv_pkg::imem_awidth-1:0] imem_addr,
    input  logic [rv_pkg::xlen-1:0]        imem_wdata,
    output logic                           io_valid,
    output logic [rv_pkg::xlen-1:0]        io_addr,
    output logic [rv_pkg::xlen-1:0]        io_data
);
    import rv_pkg::*;

    // Fetch and decode
    logic [xlen-1:0]           pc_if;
    logic [xlen-1:0]           pc_id;
    logic [xlen-1:0]           next_pc;
    logic                      kill_id;
    logic [xlen-1:0]           instr_mem;
    logic [xlen-1:0]           instr_id;
    alu_op_t                   alu_op_id;
    logic                      a_sel_pc_id;
    logic                      b_sel_imm_id;
    logic                      reg_we_id;
    logic                      is_load_id;
    logic                      is_store_id;
    logic                      is_branch_id;
    logic                      is_jal_id;
    logic                      is_jalr_id;
    wb_sel_t                   wb_sel_id;
    logic [xlen-1:0]           imm_id;
    logic [xlen-1:0]           rd1;
    logic [xlen-1:0]           rd2;
    logic [1:0]                fwd_id_a;
    logic [1:0]                fwd_id_b;
    logic [xlen-1:0]           op_a_id;
    logic [xlen-1:0]           op_b_id;

    // Execute
    alu_op_t                   alu_op_x;
    logic                      a_sel_pc_x;
    logic                      b_sel_imm_x;
    logic                      reg_we_x;
    logic                      is_load_x;
    logic                      is_store_x;
    logic                      is_branch_x;
    logic                      is_jalr_x;
    wb_sel_t                   wb_sel_x;
    logic [xlen-1:0]           pc_x;
    logic [xlen-1:0]           imm_x;
    logic [xlen-1:0]           rs1_val_x;
    logic [xlen-1:0]           rs2_val_x;
    logic [reg_addr_width-1:0] rd_x;
    logic [reg_addr_width-1:0] rs1_x;
    logic [reg_addr_width-1:0] rs2_x;
    logic [2:0]                funct3_x;
    logic                      fwd_x_a;
    logic                      fwd_x_b;
    logic [xlen-1:0]           op_a_x;
    logic [xlen-1:0]           op_b_x;
    logic [xlen-1:0]           alu_res_x;
    logic                      branch_taken_x;
    logic                      redirect_x;
    logic [xlen-1:0]           target_x;
    logic [xlen-1:0]           x_result;
    logic                      io_sel_x;

    // Write-back
    logic                      reg_we_wb;
    wb_sel_t                   wb_sel_wb;
    logic [reg_addr_width-1:0] rd_wb;
    logic [xlen-1:0]           res_wb;
    logic [xlen-1:0]           dmem_rdata;
    logic [xlen-1:0]           wb_data;

    function automatic logic [xlen-1:0] fwd_pick(input logic [1:0]      sel,
                                                 input logic [xlen-1:0] rf,
                                                 input logic [xlen-1:0] xr,
                                                 input logic [xlen-1:0] wb);
        case (sel)
            2'd1:    return xr;
            2'd2:    return wb;
            default: return rf;
        endcase
    endfunction

    ////////////////////////////////////////
    // Fetch / decode
    ////////////////////////////////////////

    // Execute redirect wins over a JAL in decode
    always_comb begin
        if (redirect_x) begin
            next_pc = target_x;
        end else if (is_jal_id) begin
            next_pc = pc_id + imm_id;
        end else begin
            next_pc = pc_if + xlen'(4);
        end
    end

    // kill_id squashes the word arriving after a redirect,
    // and the stale word on the first cycle out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_if   <= reset_pc;
            kill_id <= 1'b1;
        end else begin
            pc_if   <= next_pc;
            kill_id <= redirect_x || is_jal_id;
        end
    end

    always_ff @(posedge clk) begin
        pc_id <= pc_if;
    end

    rv_sync_ram #(.awidth(imem_awidth)) imem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_addr),
        .wdata (imem_wdata),
        .raddr (pc_if[imem_awidth+1:2]),
        .rdata (instr_mem)
    );

    assign instr_id = kill_id ? nop_instr : instr_mem;

    rv_decode decode (
        .instr     (instr_id),
        .alu_op    (alu_op_id),
        .a_sel_pc  (a_sel_pc_id),
        .b_sel_imm (b_sel_imm_id),
        .reg_we    (reg_we_id),
        .is_load   (is_load_id),
        .is_store  (is_store_id),
        .is_branch (is_branch_id),
        .is_jal    (is_jal_id),
        .is_jalr   (is_jalr_id),
        .wb_sel    (wb_sel_id),
        .imm       (imm_id)
    );

    rv_regfile regfile (
        .clk (clk),
        .ra1 (instr_id[19:15]),
        .ra2 (instr_id[24:20]),
        .rd1 (rd1),
        .rd2 (rd2),
        .wa  (rd_wb),
        .wd  (wb_data),
        .we  (reg_we_wb)
    );

    // A load in execute has no result yet, so decode skips it
    rv_forward forward (
        .rs1_id    (instr_id[19:15]),
        .rs2_id    (instr_id[24:20]),
        .rd_x      (rd_x),
        .rd_wb     (rd_wb),
        .rs1_x     (rs1_x),
        .rs2_x     (rs2_x),
        .reg_we_x  (reg_we_x && !is_load_x),
        .reg_we_wb (reg_we_wb),
        .fwd_id_a  (fwd_id_a),
        .fwd_id_b  (fwd_id_b),
        .fwd_x_a   (fwd_x_a),
        .fwd_x_b   (fwd_x_b)
    );

    assign op_a_id = fwd_pick(fwd_id_a, rd1, x_result, wb_data);
    assign op_b_id = fwd_pick(fwd_id_b, rd2, x_result, wb_data);

    // Decode to execute, bubble on reset or redirect
    always_ff @(posedge clk) begin
        if (reset || redirect_x) begin
            alu_op_x    <= alu_add;
            a_sel_pc_x  <= 1'b0;
            b_sel_imm_x <= 1'b0;
            reg_we_x    <= 1'b0;
            is_load_x   <= 1'b0;
            is_store_x  <= 1'b0;
            is_branch_x <= 1'b0;
            is_jalr_x   <= 1'b0;
            wb_sel_x    <= wb_alu;
        end else begin
            alu_op_x    <= alu_op_id;
            a_sel_pc_x  <= a_sel_pc_id;
            b_sel_imm_x <= b_sel_imm_id;
            reg_we_x    <= reg_we_id;
            is_load_x   <= is_load_id;
            is_store_x  <= is_store_id;
            is_branch_x <= is_branch_id;
            is_jalr_x   <= is_jalr_id;
            wb_sel_x    <= wb_sel_id;
        end
    end

    always_ff @(posedge clk) begin
        pc_x      <= pc_id;
        imm_x     <= imm_id;
        rs1_val_x <= op_a_id;
        rs2_val_x <= op_b_id;
        rd_x      <= instr_id[11:7];
        rs1_x     <= instr_id[19:15];
        rs2_x     <= instr_id[24:20];
        funct3_x  <= instr_id[14:12];
    end

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////

    assign op_a_x = fwd_x_a ? wb_data : rs1_val_x;
    assign op_b_x = fwd_x_b ? wb_data : rs2_val_x;

    rv_alu alu (
        .a            (a_sel_pc_x ? pc_x : op_a_x),
        .b            (b_sel_imm_x ? imm_x : op_b_x),
        .op           (alu_op_x),
        .funct3       (funct3_x),
        .result       (alu_res_x),
        .branch_taken (branch_taken_x)
    );

    assign redirect_x = is_jalr_x || (is_branch_x && branch_taken_x);
    assign target_x   = is_jalr_x ? {alu_res_x[xlen-1:1], 1'b0} : pc_x + imm_x;

    // Link value for jumps, ALU result otherwise
    assign x_result = (wb_sel_x == wb_pc_plus4) ? pc_x + xlen'(4) : alu_res_x;

    // Bit 31 picks the output port over data memory
    assign io_sel_x = (alu_res_x & io_base) == io_base;

    rv_sync_ram #(.awidth(dmem_awidth)) dmem (
        .clk   (clk),
        .we    (is_store_x && !io_sel_x),
        .waddr (alu_res_x[dmem_awidth+1:2]),
        .wdata (op_b_x),
        .raddr (alu_res_x[dmem_awidth+1:2]),
        .rdata (dmem_rdata)
    );

    ////////////////////////////////////////
    // Write-back
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_we_wb <= 1'b0;
            wb_sel_wb <= wb_alu;
            io_valid  <= 1'b0;
        end else begin
            reg_we_wb <= reg_we_x;
            wb_sel_wb <= wb_sel_x;
            io_valid  <= is_store_x && io_sel_x;
        end
    end

    always_ff @(posedge clk) begin
        rd_wb  <= rd_x;
        res_wb <= x_result;
        if (is_store_x && io_sel_x) begin
            io_addr <= alu_res_x;
            io_data <= op_b_x;
        end
    end

    assign wb_data = (wb_sel_wb == wb_mem) ? dmem_rdata : res_wb;

endmodule

//--- rtl/rv_decode.sv
module rv_decode (
    input  logic [rv_pkg::xlen-1:0] instr,
    output rv_pkg::alu_op_t         alu_op,
    output logic                    a_sel_pc,
    output logic                    b_sel_imm,
    output logic                    reg_we,
    output logic                    is_load,
    output logic                    is_store,
    output logic                    is_branch,
    output logic                    is_jal,
    output logic                    is_jalr,
    output rv_pkg::wb_sel_t         wb_sel,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    alu_op_t         arith_op;

    assign funct3 = instr[14:12];

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // ALU op shared by OP and OP-IMM
    // instr[5] tells the register form apart, SUB exists only there
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (instr[30] && instr[5]) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = instr[30] ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        // Everything inactive, unknown opcodes end up as a bubble
        alu_op    = alu_add;
        a_sel_pc  = 1'b0;
        b_sel_imm = 1'b0;
        reg_we    = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        wb_sel    = wb_alu;
        imm       = imm_i;
        case (opcode_t'(instr[6:0]))
            opc_op: begin
                alu_op = arith_op;
                reg_we = 1'b1;
            end
            opc_op_imm: begin
                alu_op    = arith_op;
                b_sel_imm = 1'b1;
                reg_we    = 1'b1;
            end
            opc_lui: begin
                alu_op    = alu_pass_b;
                b_sel_imm = 1'b1;
                reg_we    = 1'b1;
                imm       = imm_u;
            end
            opc_jal: begin
                a_sel_pc  = 1'b1;
                b_sel_imm = 1'b1;
                reg_we    = 1'b1;
                is_jal    = 1'b1;
                wb_sel    = wb_pc_plus4;
                imm       = imm_j;
            end
            opc_jalr: begin
                b_sel_imm = 1'b1;
                reg_we    = 1'b1;
                is_jalr   = 1'b1;
                wb_sel    = wb_pc_plus4;
            end
            opc_branch: begin
                is_branch = 1'b1;
                imm       = imm_b;
            end
            opc_load: begin
                // Word access only
                if (funct3 == 3'b010) begin
                    b_sel_imm = 1'b1;
                    reg_we    = 1'b1;
                    is_load   = 1'b1;
                    wb_sel    = wb_mem;
                end
            end
            opc_store: begin
                if (funct3 == 3'b010) begin
                    b_sel_imm = 1'b1;
                    is_store  = 1'b1;
                    imm       = imm_s;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- rtl/rv_forward.sv
module rv_forward (
    input  logic [rv_pkg::reg_addr_width-1:0] rs1_id,
    input  logic [rv_pkg::reg_addr_width-1:0] rs2_id,
    input  logic [rv_pkg::reg_addr_width-1:0] rd_x,
    input  logic [rv_pkg::reg_addr_width-1:0] rd_wb,
    input  logic [rv_pkg::reg_addr_width-1:0] rs1_x,
    input  logic [rv_pkg::reg_addr_width-1:0] rs2_x,
    input  logic                              reg_we_x,
    input  logic                              reg_we_wb,
    output logic [1:0]                        fwd_id_a,
    output logic [1:0]                        fwd_id_b,
    output logic                              fwd_x_a,
    output logic                              fwd_x_b
);
    import rv_pkg::*;

    // Writer targets this source, x0 never forwards
    function automatic logic hit(input logic                      we,
                                 input logic [reg_addr_width-1:0] rd,
                                 input logic [reg_addr_width-1:0] rs);
        return we && (rd == rs) && (rs != '0);
    endfunction

    // Decode select 0 regfile, 1 execute, 2 write-back
    assign fwd_id_a = hit(reg_we_x, rd_x, rs1_id)   ? 2'd1 :
                      hit(reg_we_wb, rd_wb, rs1_id) ? 2'd2 : 2'd0;
    assign fwd_id_b = hit(reg_we_x, rd_x, rs2_id)   ? 2'd1 :
                      hit(reg_we_wb, rd_wb, rs2_id) ? 2'd2 : 2'd0;

    // Catches load data that was not ready in decode
    assign fwd_x_a = hit(reg_we_wb, rd_wb, rs1_x);
    assign fwd_x_b = hit(reg_we_wb, rd_wb, rs2_x);

endmodule

//--- rtl/rv_pkg.sv
package rv_pkg;

    // Datapath and register index widths
    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;

    // Word-address widths of the two memories
    localparam int imem_awidth = 10;
    localparam int dmem_awidth = 10;

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // Any address with bit 31 set lands on the output port
    localparam logic [xlen-1:0] io_base = 32'h8000_0000;

    // ADDI x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    // Major opcodes that the core executes
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    // Write-back source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc_plus4
    } wb_sel_t;

endpackage

//--- rtl/rv_regfile.sv
module rv_regfile (
    input  logic                              clk,
    input  logic [rv_pkg::reg_addr_width-1:0] ra1,
    input  logic [rv_pkg::reg_addr_width-1:0] ra2,
    output logic [rv_pkg::xlen-1:0]           rd1,
    output logic [rv_pkg::xlen-1:0]           rd2,
    input  logic [rv_pkg::reg_addr_width-1:0] wa,
    input  logic [rv_pkg::xlen-1:0]           wd,
    input  logic                              we
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_width];

    // Entry 0 is never written
    always_ff @(posedge clk) begin
        if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // x0 reads as zero
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

//--- rtl/rv_sync_ram.sv
module rv_sync_ram #(
    parameter int awidth = 10
) (
    input  logic                    clk,
    input  logic                    we,
    input  logic [awidth-1:0]       waddr,
    input  logic [rv_pkg::xlen-1:0] wdata,
    input  logic [awidth-1:0]       raddr,
    output logic [rv_pkg::xlen-1:0] rdata
);
    import rv_pkg::*;

    logic [xlen-1:0] mem [2**awidth];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- rv_core.f
rtl/rv_pkg.sv
rtl/rv_sync_ram.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_forward.sv
rtl/rv_alu.sv
rtl/rv_core.sv
sim/rv_clock_gen.sv
sim/rv_core_props.sv
sim/rv_core_tb.sv

//--- sim/rv_clock_gen.sv
module rv_clock_gen #(
    parameter int period_ns = 8
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    logic clk_q = 1'b0;

    // Free running, first rising edge after half a period
    always begin
        #(period_ns / 2) clk_q = ~clk_q;
    end

    assign clk = clk_q;

endmodule

//--- sim/rv_core_props.sv
module rv_core_props (
    input logic                    clk,
    input logic                    reset,
    input logic                    io_valid,
    input logic [rv_pkg::xlen-1:0] io_addr,
    input logic [rv_pkg::xlen-1:0] io_data
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Output port quiet in reset and on the cycle after release
    io_quiet_in_reset: assert property (@(posedge clk) $past(reset) |-> !io_valid)
        else begin
            $error("io_valid high during reset or on the cycle after it");
            fail_count++;
        end

    // Pulses only land in output space, on word boundaries
    io_addr_legal: assert property (@(posedge clk) disable iff (reset)
        io_valid |-> (io_addr[31] && (io_addr[1:0] == 2'b00)))
        else begin
            $error("io_addr outside output space or not word aligned");
            fail_count++;
        end

    io_data_known: assert property (@(posedge clk) disable iff (reset)
        io_valid |-> !$isunknown(io_data))
        else begin
            $error("io_data has unknown bits during a pulse");
            fail_count++;
        end

endmodule

bind rv_core rv_core_props props_i (.*);

//--- sim/rv_core_tb.sv
module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int seed            = 45;
    localparam int num_tests       = 5;
    localparam int reset_cycles    = 10;
    localparam int test_cycles     = 300;
    localparam int max_prog_words  = 100;
    localparam int watchdog_cycles = num_tests * (test_cycles + max_prog_words + reset_cycles);

    // Major opcodes for the I-type encoder
    localparam logic [31:0] code_arith = 32'h13;
    localparam logic [31:0] code_load  = 32'h03;
    localparam logic [31:0] code_jalr  = 32'h67;

    logic                   clk;
    logic                   reset;
    logic                   imem_we;
    logic [imem_awidth-1:0] imem_addr;
    logic [xlen-1:0]        imem_wdata;
    logic                   io_valid;
    logic [xlen-1:0]        io_addr;
    logic [xlen-1:0]        io_data;

    logic [31:0] prog[$];
    logic [31:0] exp_q[$];
    logic [31:0] exp_word;
    string       test_name;
    int          err_count = 0;

    rv_clock_gen #(.period_ns(8)) clock_i (.clk(clk));

    rv_core rv_core_i (
        .clk        (clk),
        .reset      (reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .io_valid   (io_valid),
        .io_addr    (io_addr),
        .io_data    (io_data)
    );

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////

    function automatic logic [31:0] r_type(input logic [31:0] f7, input logic [31:0] f3,
                                           input logic [31:0] rd, input logic [31:0] rs1,
                                           input logic [31:0] rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] opc, input logic [31:0] f3,
                                           input logic [31:0] rd, input logic [31:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] s_word(input logic [31:0] rs2, input logic [31:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] f3, input logic [31:0] rs1,
                                           input logic [31:0] rs2, input logic [31:0] off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [31:0] rd, input logic [31:0] value);
        return {value[31:12], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] jal_word(input logic [31:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    ////////////////////////////////////////
    // Reference results from RV32I rules
    ////////////////////////////////////////

    function automatic logic [31:0] alu_ref(input logic [31:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3[2:0])
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [31:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3[2:0])
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] rand_imm12();
        logic [31:0] r;
        r = $urandom;
        return {{20{r[11]}}, r[11:0]};
    endfunction

    ////////////////////////////////////////
    // Program building and running
    ////////////////////////////////////////

    function automatic logic [31:0] here();
        return 32'(prog.size() * 4);
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // LUI + ADDI with the upper part rounded for the signed low half
    task automatic load_const(input logic [31:0] rd, input logic [31:0] value);
        emit(lui_word(rd, value + 32'h800));
        emit(i_type(code_arith, 0, rd, rd, value));
    endtask

    // x31 holds the output port address
    task automatic store_out(input logic [31:0] rs);
        emit(s_word(rs, 31, 0));
    endtask

    task automatic begin_program(input string name);
        test_name = name;
        prog.delete();
        emit(lui_word(31, io_base));
    endtask

    task automatic run_program();
        @(posedge clk);
        #1;
        reset = 1'b1;
        foreach (prog[i]) begin
            @(posedge clk);
            #1;
            imem_we    = 1'b1;
            imem_addr  = imem_awidth'(i);
            imem_wdata = prog[i];
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // Quiet period in which the monitor flags any extra pulse
        repeat (20) @(negedge clk);
    endtask

    // Self loop with a store in the JAL shadow
    task automatic end_program();
        emit(jal_word(0, 0));
        store_out(0);
        run_program();
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic reg_op(input logic [31:0] f7, input logic [31:0] f3,
                          input logic [31:0] a, input logic [31:0] b);
        emit(r_type(f7, f3, 3, 1, 2));
        store_out(3);
        exp_q.push_back(alu_ref(f3, f7[5], a, b));
    endtask

    task automatic imm_op(input logic [31:0] f3, input logic [31:0] imm, input logic [31:0] a);
        emit(i_type(code_arith, f3, 4, 1, imm));
        store_out(4);
        exp_q.push_back(alu_ref(f3, (f3[2:0] == 3'd5) && imm[10], a, imm));
    endtask

    task automatic alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sh;
        begin_program("alu");
        a = $urandom;
        b = $urandom;
        load_const(1, a);
        load_const(2, b);
        for (int f3 = 0; f3 < 8; f3++) begin
            reg_op(0, f3, a, b);
        end
        reg_op(32'h20, 0, a, b);
        reg_op(32'h20, 5, a, b);
        imm_op(0, rand_imm12(), a);
        imm_op(4, rand_imm12(), a);
        imm_op(2, rand_imm12(), a);
        sh = $urandom_range(31, 0);
        imm_op(1, sh, a);
        imm_op(5, sh | 32'h400, a);
        end_program();
    endtask

    task automatic forwarding_chain();
        logic [31:0] sum;
        logic [31:0] imm;
        begin_program("forwarding");
        sum = $urandom;
        load_const(5, sum);
        // Each ADDI reads the one just before it
        for (int k = 0; k < 8; k++) begin
            imm = rand_imm12();
            emit(i_type(code_arith, 0, k + 6, k + 5, imm));
            sum = sum + imm;
        end
        store_out(13);
        exp_q.push_back(sum);
        end_program();
    endtask

    task automatic branch_decisions();
        int          n;
        int          conds [5] = '{0, 4, 5, 6, 7};
        logic [31:0] loop_pc;
        logic [31:0] a;
        logic [31:0] b;
        begin_program("branches");
        n = $urandom_range(12, 3);
        emit(i_type(code_arith, 0, 1, 0, n));
        emit(i_type(code_arith, 0, 2, 0, 0));
        emit(i_type(code_arith, 0, 3, 0, 0));
        loop_pc = here();
        emit(i_type(code_arith, 0, 3, 3, 1));
        emit(r_type(0, 0, 2, 2, 3));
        emit(b_type(1, 3, 1, loop_pc - here()));
        // Both stores sit in the shadow of every taken BNE
        store_out(2);
        store_out(3);
        exp_q.push_back(32'(n * (n + 1) / 2));
        exp_q.push_back(32'(n));
        for (int k = 0; k < 5; k++) begin
            a = $urandom;
            b = ($urandom_range(1, 0) != 0) ? a : $urandom;
            load_const(10, a);
            load_const(11, b);
            emit(i_type(code_arith, 0, 12, 0, k + 1));
            emit(b_type(conds[k], 10, 11, 8));
            store_out(12);
            if (!branch_ref(conds[k], a, b)) begin
                exp_q.push_back(32'(k + 1));
            end
        end
        end_program();
    endtask

    task automatic jump_links();
        logic [31:0] p;
        begin_program("jumps");
        p = here();
        emit(jal_word(1, 8));
        store_out(0);
        store_out(1);
        exp_q.push_back(p + 4);
        // JALR target built odd so that bit 0 has to be cleared
        p = here();
        emit(i_type(code_arith, 0, 5, 0, p + 9));
        emit(i_type(code_jalr, 0, 6, 5, 8));
        store_out(0);
        store_out(0);
        // The link of a JAL at the target would show a PC with bit 0 still set
        emit(jal_word(7, 8));
        store_out(0);
        store_out(6);
        store_out(7);
        exp_q.push_back(p + 8);
        exp_q.push_back(p + 20);
        end_program();
    endtask

    task automatic load_store_words();
        logic [31:0] w [3];
        begin_program("memory");
        foreach (w[k]) begin
            w[k] = $urandom;
            load_const(k + 1, w[k]);
        end
        emit(s_word(1, 0, 32'h010));
        emit(s_word(2, 0, 32'h024));
        emit(s_word(3, 0, 32'h03c));
        // Every load is used by the very next instruction
        emit(i_type(code_load, 2, 4, 0, 32'h010));
        emit(r_type(0, 0, 5, 4, 2));
        store_out(5);
        emit(i_type(code_load, 2, 6, 0, 32'h024));
        emit(r_type(0, 0, 7, 6, 6));
        store_out(7);
        emit(i_type(code_load, 2, 8, 0, 32'h03c));
        emit(r_type(0, 0, 9, 1, 8));
        store_out(9);
        emit(i_type(code_load, 2, 10, 0, 32'h010));
        store_out(10);
        exp_q.push_back(w[0] + w[1]);
        exp_q.push_back(w[1] + w[1]);
        exp_q.push_back(w[0] + w[2]);
        exp_q.push_back(w[0]);
        end_program();
    endtask

    ////////////////////////////////////////
    // Output port monitor
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!reset && io_valid) begin
            assert (io_addr == io_base) else begin
                $display("ERR %s io_addr expected %h actual %h", test_name, io_base, io_addr);
                err_count++;
            end
            assert (exp_q.size() != 0) else begin
                $display("%s: output pulse with data %h when none was expected",
                         test_name, io_data);
                err_count++;
            end
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                assert (io_data == exp_word) else begin
                    $display("ERR %s expected %h actual %h", test_name, exp_word, io_data);
                    err_count++;
                end
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(seed));
        reset      = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        alu_ops();
        forwarding_chain();
        branch_decisions();
        jump_links();
        load_store_words();
        $display("Errors: %0d data checks, %0d assertions", err_count,
                 rv_core_i.props_i.fail_count);
        if ((err_count == 0) && (rv_core_i.props_i.fail_count == 0)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
